// ==== mam_adapter_wb.sv ====
// Debug and CPU Wishbone arbiter
`timescale 1ns/1ps

module mam_adapter_wb
  import mam_pkg::*;
(
  input  logic    wb_in_clk_i,
  input  logic    wb_in_rst_i,
  // CPU port
  input  wb_req_t cpu_req_i,
  output wb_rsp_t cpu_rsp_o,
  // Debug master port
  input  wb_req_t mam_req_i,
  output wb_rsp_t mam_rsp_o,
  // Toward the memory
  output wb_req_t mem_req_o,
  input  wb_rsp_t mem_rsp_i
);

  // Arbiter states, debug side has priority
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_MAM,
    ARB_CPU
  } arb_state_e;

  arb_state_e arb_q;
  arb_state_e arb_d;
  logic       access_cpu;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  always_comb begin
    arb_d = ARB_IDLE;
    case (arb_q)
      ARB_IDLE: begin
        // Debug wins a tie
        if (mam_req_i.cyc) begin
          arb_d = ARB_MAM;
        end else if (cpu_req_i.cyc) begin
          arb_d = ARB_CPU;
        end
      end
      ARB_MAM: begin
        if (mam_req_i.cyc) begin
          arb_d = ARB_MAM;
        end
      end
      ARB_CPU: begin
        // A started CPU cycle runs to its end
        if (cpu_req_i.cyc) begin
          arb_d = ARB_CPU;
        end else if (mam_req_i.cyc) begin
          arb_d = ARB_MAM;
        end
      end
      default: arb_d = ARB_IDLE;
    endcase
  end

  // Select flag registered next to the state
  // so the mux is driven straight from a flop
  always_ff @(posedge wb_in_clk_i) begin
    if (wb_in_rst_i) begin
      arb_q      <= ARB_IDLE;
      access_cpu <= 1'b0;
    end else begin
      arb_q      <= arb_d;
      access_cpu <= (arb_d == ARB_CPU);
    end
  end

  ////////////////////////////////////////
  // Request and response steering
  ////////////////////////////////////////

  // Debug lines pass when the CPU is not selected
  assign mem_req_o = access_cpu ? cpu_req_i : mam_req_i;

  // Other side sees ack, err and data at zero
  assign cpu_rsp_o = access_cpu ? mem_rsp_i : '0;
  assign mam_rsp_o = access_cpu ? '0 : mem_rsp_i;

endmodule

// ==== mam_cmd_decoder.sv ====
// Debug command decoder
`timescale 1ns/1ps

module mam_cmd_decoder
  import mam_pkg::*;
(
  input  logic      wb_in_clk_i,
  input  logic      wb_in_rst_i,
  input  logic      dbg_valid_i,
  input  dbg_word_u dbg_word_i,
  input  logic      req_take_i,
  output logic      dbg_busy_o,
  output logic      req_valid_o,
  output mam_req_t  req_o
);

  // Position of the next expected host word
  typedef enum logic [1:0] {
    ST_HDR,
    ST_ADR,
    ST_DAT
  } word_state_e;

  word_state_e state_q;
  word_state_e state_d;
  mam_req_t    cmd_q;
  mam_req_t    cmd_d;
  logic        cmd_done;
  logic        hdr_ok;
  logic        word_stb;
  logic        out_free;
  logic        pend_q;
  logic        out_valid_q;
  mam_req_t    out_q;

  // Words are dropped while a finished command waits
  assign word_stb = dbg_valid_i & ~pend_q;

  // Output slot can be loaded this cycle
  assign out_free = ~out_valid_q | req_take_i;

  // Opcode and we bit have to agree
  assign hdr_ok = ((dbg_word_i.hdr.opcode == DBG_OP_READ) & ~dbg_word_i.hdr.we) |
                  ((dbg_word_i.hdr.opcode == DBG_OP_WRITE) & dbg_word_i.hdr.we);

  ////////////////////////////////////////
  // Word collection
  ////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    cmd_d    = cmd_q;
    cmd_done = 1'b0;
    if (word_stb) begin
      case (state_q)
        ST_HDR: begin
          // Invalid header is ignored, stay here
          if (hdr_ok) begin
            cmd_d.we  = dbg_word_i.hdr.we;
            cmd_d.sel = dbg_word_i.hdr.sel;
            cmd_d.dat = '0;
            state_d   = ST_ADR;
          end
        end
        ST_ADR: begin
          cmd_d.adr = dbg_word_i.raw;
          if (cmd_q.we) begin
            state_d = ST_DAT;
          end else begin
            // Read is complete after the address
            state_d  = ST_HDR;
            cmd_done = 1'b1;
          end
        end
        ST_DAT: begin
          cmd_d.dat = dbg_word_i.raw;
          state_d   = ST_HDR;
          cmd_done  = 1'b1;
        end
        default: state_d = ST_HDR;
      endcase
    end
  end

  ////////////////////////////////////////
  // Output register and pending slot
  ////////////////////////////////////////

  always_ff @(posedge wb_in_clk_i) begin
    if (wb_in_rst_i) begin
      state_q     <= ST_HDR;
      pend_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (out_free) begin
        // Either a fresh command or the parked one moves out
        out_valid_q <= cmd_done | pend_q;
        pend_q      <= 1'b0;
      end else if (cmd_done) begin
        pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge wb_in_clk_i) begin
    cmd_q <= cmd_d;
    if (out_free && cmd_done) begin
      out_q <= cmd_d;
    end else if (out_free && pend_q) begin
      out_q <= cmd_q;
    end
  end

  // Busy only while a complete command is parked
  assign dbg_busy_o  = pend_q;
  assign req_valid_o = out_valid_q;
  assign req_o       = out_q;

endmodule

// ==== mam_pkg.sv ====
// Debug memory access types
`include "mam_settings.svh"

package mam_pkg;

  ////////////////////////////////////////
  // Wishbone classic cycle
  ////////////////////////////////////////

  // Master side of one classic single cycle
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`MAM_DW/8-1:0]      sel;
    logic [`MAM_AW-1:0]        adr;
    logic [`MAM_DW-1:0]        dat;
  } wb_req_t;

  // Slave side, no retry
  typedef struct packed {
    logic                      ack;
    logic                      err;
    logic [`MAM_DW-1:0]        dat;
  } wb_rsp_t;

  ////////////////////////////////////////
  // Debug host words
  ////////////////////////////////////////

  // Opcodes in the header word
  localparam logic [1:0] DBG_OP_READ  = 2'b01;
  localparam logic [1:0] DBG_OP_WRITE = 2'b10;

  // Header word, opcode in the top bits
  typedef struct packed {
    logic [1:0]                opcode;
    logic                      we;
    logic [3:0]                sel;
    logic [24:0]               rsvd;
  } dbg_hdr_t;

  // One host word, seen as header or as plain address/data
  typedef union packed {
    dbg_hdr_t                  hdr;
    logic [`MAM_DW-1:0]        raw;
  } dbg_word_u;

  // Fully assembled debug request, no bus control
  typedef struct packed {
    logic                      we;
    logic [`MAM_DW/8-1:0]      sel;
    logic [`MAM_AW-1:0]        adr;
    logic [`MAM_DW-1:0]        dat;
  } mam_req_t;

endpackage

// ==== mam_settings.svh ====
// Debug memory access settings
`ifndef MAM_SETTINGS_SVH
`define MAM_SETTINGS_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

// Byte address width on every Wishbone port
`define MAM_AW 32

// Data width, one word per access
`define MAM_DW 32

////////////////////////////////////////
// Memory
////////////////////////////////////////

// Depth of the RAM slave in words
// Word indices at or above this value get err
`define MAM_MEM_WORDS 256

`endif

// ==== mam_soc_assert.sv ====
// Arbiter and memory port assertions
`timescale 1ns/1ps

module mam_soc_assert
  import mam_pkg::*;
(
  input logic    wb_in_clk_i,
  input logic    wb_in_rst_i,
  input logic    access_cpu_i,
  input wb_req_t cpu_req_i,
  input wb_rsp_t cpu_rsp_i,
  input wb_req_t mam_req_i,
  input wb_rsp_t mam_rsp_i,
  input wb_req_t mem_req_i,
  input wb_rsp_t mem_rsp_i
);

  // Number of failed assertions so far
  int fail_cnt = 0;

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  // One kind of response at a time
  ack_err_excl: assert property (@(posedge wb_in_clk_i) disable iff (wb_in_rst_i)
    !(mem_rsp_i.ack && mem_rsp_i.err))
    else begin
      fail_cnt++;
      $error("memory drove ack and err in the same cycle");
    end

  // stb only inside a cycle
  stb_in_cyc: assert property (@(posedge wb_in_clk_i) disable iff (wb_in_rst_i)
    mem_req_i.stb |-> mem_req_i.cyc)
    else begin
      fail_cnt++;
      $error("memory saw stb without cyc");
    end

  ////////////////////////////////////////
  // Arbiter side
  ////////////////////////////////////////

  // Debug side answered only for a cycle of its own that reached the memory
  mam_quiet: assert property (@(posedge wb_in_clk_i) disable iff (wb_in_rst_i)
    (mam_rsp_i.ack || mam_rsp_i.err) |->
      $past(mam_req_i.cyc && (mem_req_i == mam_req_i)))
    else begin
      fail_cnt++;
      $error("debug side saw a response while the CPU was granted");
    end

  // Same for the CPU side
  cpu_quiet: assert property (@(posedge wb_in_clk_i) disable iff (wb_in_rst_i)
    (cpu_rsp_i.ack || cpu_rsp_i.err) |->
      $past(cpu_req_i.cyc && (mem_req_i == cpu_req_i)))
    else begin
      fail_cnt++;
      $error("CPU saw a response while the debug side was granted");
    end

  // A running CPU cycle keeps the grant
  cpu_hold: assert property (@(posedge wb_in_clk_i) disable iff (wb_in_rst_i)
    (access_cpu_i && cpu_req_i.cyc) |=> access_cpu_i)
    else begin
      fail_cnt++;
      $error("grant left the CPU while it held cyc");
    end

endmodule

bind mam_adapter_wb mam_soc_assert u_assert (
  .wb_in_clk_i  (wb_in_clk_i),
  .wb_in_rst_i  (wb_in_rst_i),
  .access_cpu_i (access_cpu),
  .cpu_req_i    (cpu_req_i),
  .cpu_rsp_i    (cpu_rsp_o),
  .mam_req_i    (mam_req_i),
  .mam_rsp_i    (mam_rsp_o),
  .mem_req_i    (mem_req_o),
  .mem_rsp_i    (mem_rsp_i)
);

// ==== mam_soc_tb.sv ====
// Debug memory access testbench
`timescale 1ns/1ps
`include "mam_settings.svh"

module mam_soc_tb
  import mam_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int DRV_DLY    = 2;
  localparam int RAND_OPS   = 200;
  // Worst case of one access, host words and a blocked grant included
  localparam int OP_WORST   = 24;
  localparam int OP_COUNT   = RAND_OPS + 24;
  localparam int TIMEOUT_CYCLES = 2 * OP_WORST * OP_COUNT;

  logic               wb_in_clk;
  logic               wb_in_rst;
  logic               dbg_valid;
  dbg_word_u          dbg_word;
  logic               dbg_busy;
  logic               rsp_valid;
  logic [`MAM_DW-1:0] rdata;
  logic               err;
  wb_req_t            cpu_req;
  wb_rsp_t            cpu_rsp;

  // Reference memory, X where never written
  logic [`MAM_DW-1:0] ref_mem [`MAM_MEM_WORDS];

  int          errors = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  time         t_dbg;
  time         t_cpu;
  logic        r_we;
  logic [3:0]  r_sel;
  logic [31:0] r_adr;
  logic [31:0] r_dat;
  int unsigned r_idx;
  logic [31:0] rd_d;
  logic [31:0] rd_c;
  logic        e_d;
  logic        e_c;

  mam_soc_top u_dut (
    .wb_in_clk_i (wb_in_clk),
    .wb_in_rst_i (wb_in_rst),
    .dbg_valid_i (dbg_valid),
    .dbg_word_i  (dbg_word),
    .dbg_busy_o  (dbg_busy),
    .rsp_valid_o (rsp_valid),
    .rdata_o     (rdata),
    .err_o       (err),
    .cpu_req_i   (cpu_req),
    .cpu_rsp_o   (cpu_rsp)
  );

  initial begin
    wb_in_clk = 1'b0;
    forever #(CLK_PERIOD / 2) wb_in_clk = ~wb_in_clk;
  end

  // Run limit
  always @(posedge wb_in_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic adr_in_range(input logic [31:0] adr);
    return (adr[`MAM_AW-1:2] < `MAM_MEM_WORDS);
  endfunction

  // Byte lanes chosen by sel replace the old word
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic int total_errors();
    return errors + u_dut.u_adapter.u_assert.fail_cnt;
  endfunction

  function automatic logic [31:0] hdr_word(input logic we, input logic [3:0] sel);
    dbg_word_u h;
    h.raw        = '0;
    h.hdr.opcode = we ? DBG_OP_WRITE : DBG_OP_READ;
    h.hdr.we     = we;
    h.hdr.sel    = sel;
    return h.raw;
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("Error at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  // Err for out of range, else read data against the model
  task automatic check_result(input string side, input logic we, input logic [3:0] sel,
                              input logic [31:0] adr, input logic [31:0] dat,
                              input logic [31:0] rd, input logic e);
    if (!adr_in_range(adr)) begin
      check(e, $sformatf("%s access to %h gave no err", side, adr));
    end else begin
      check(!e, $sformatf("%s access to %h gave err", side, adr));
      if (we) begin
        ref_mem[adr[`MAM_AW-1:2]] = merge_lanes(ref_mem[adr[`MAM_AW-1:2]], dat, sel);
      end else begin
        check(rd === ref_mem[adr[`MAM_AW-1:2]],
              $sformatf("%s read %h got %h, expected %h", side, adr, rd,
                        ref_mem[adr[`MAM_AW-1:2]]));
      end
    end
  endtask

  ////////////////////////////////////////
  // Host and CPU drivers
  ////////////////////////////////////////

  // One strobed word, held back while busy
  task automatic host_word(input logic [31:0] w);
    @(posedge wb_in_clk);
    #DRV_DLY;
    while (dbg_busy) begin
      @(posedge wb_in_clk);
      #DRV_DLY;
    end
    dbg_valid    = 1'b1;
    dbg_word.raw = w;
    @(posedge wb_in_clk);
    #DRV_DLY;
    dbg_valid = 1'b0;
  endtask

  task automatic dbg_send(input logic we, input logic [3:0] sel,
                          input logic [31:0] adr, input logic [31:0] dat);
    host_word(hdr_word(we, sel));
    host_word(adr);
    if (we) begin
      host_word(dat);
    end
  endtask

  task automatic dbg_wait(output logic [31:0] rd, output logic e);
    do begin
      @(posedge wb_in_clk);
      #DRV_DLY;
    end while (!rsp_valid);
    rd    = rdata;
    e     = err;
    t_dbg = $time;
  endtask

  // Classic cycle, cyc dropped the cycle after ack or err
  task automatic cpu_access(input logic we, input logic [3:0] sel,
                            input logic [31:0] adr, input logic [31:0] dat,
                            output logic [31:0] rd, output logic e);
    @(posedge wb_in_clk);
    #DRV_DLY;
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;
    cpu_req.we  = we;
    cpu_req.sel = sel;
    cpu_req.adr = adr;
    cpu_req.dat = dat;
    do begin
      @(posedge wb_in_clk);
      #DRV_DLY;
    end while (!(cpu_rsp.ack || cpu_rsp.err));
    rd    = cpu_rsp.dat;
    e     = cpu_rsp.err;
    t_cpu = $time;
    @(posedge wb_in_clk);
    #DRV_DLY;
    cpu_req.cyc = 1'b0;
    cpu_req.stb = 1'b0;
  endtask

  task automatic dbg_op(input logic we, input logic [3:0] sel,
                        input logic [31:0] adr, input logic [31:0] dat);
    dbg_send(we, sel, adr, dat);
    dbg_wait(rd_d, e_d);
    check_result("debug", we, sel, adr, dat, rd_d, e_d);
  endtask

  task automatic cpu_op(input logic we, input logic [3:0] sel,
                        input logic [31:0] adr, input logic [31:0] dat);
    cpu_access(we, sel, adr, dat, rd_c, e_c);
    check_result("cpu", we, sel, adr, dat, rd_c, e_c);
  endtask

  task automatic end_test(input string name);
    int n;
    n = total_errors() - test_errs;
    tests_run++;
    if (n == 0) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, n);
    end
    test_errs = total_errors();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h10591380));
    wb_in_rst = 1'b1;
    dbg_valid = 1'b0;
    dbg_word  = '0;
    cpu_req   = '0;
    repeat (5) @(posedge wb_in_clk);
    #DRV_DLY;
    wb_in_rst = 1'b0;

    dbg_op(1'b1, 4'hf, 32'h10, 32'hcafe_0001);
    dbg_op(1'b0, 4'hf, 32'h10, 32'h0);
    end_test("debug write and read");

    // Partial lanes merge into one word
    cpu_op(1'b1, 4'hf, 32'h20, 32'h1122_3344);
    cpu_op(1'b1, 4'b0101, 32'h20, 32'haabb_ccdd);
    cpu_op(1'b1, 4'b1000, 32'h20, 32'h5566_7788);
    cpu_op(1'b0, 4'hf, 32'h20, 32'h0);
    dbg_op(1'b0, 4'hf, 32'h20, 32'h0);
    end_test("cpu partial writes");

    // Both cycles start from idle in the same cycle
    dbg_send(1'b0, 4'hf, 32'h10, 32'h0);
    fork
      cpu_access(1'b0, 4'hf, 32'h20, 32'h0, rd_c, e_c);
      dbg_wait(rd_d, e_d);
    join
    check_result("debug", 1'b0, 4'hf, 32'h10, 32'h0, rd_d, e_d);
    check_result("cpu", 1'b0, 4'hf, 32'h20, 32'h0, rd_c, e_c);
    check(t_dbg < t_cpu, "debug response did not come before the CPU ack");
    end_test("debug priority");

    // Debug cycle shows up while the CPU holds the bus
    host_word(hdr_word(1'b1, 4'hf));
    host_word(32'h30);
    fork
      cpu_access(1'b1, 4'hf, 32'h34, 32'h1357_9bdf, rd_c, e_c);
      begin
        host_word(32'hdead_beef);
        dbg_wait(rd_d, e_d);
      end
    join
    check_result("cpu", 1'b1, 4'hf, 32'h34, 32'h1357_9bdf, rd_c, e_c);
    check_result("debug", 1'b1, 4'hf, 32'h30, 32'hdead_beef, rd_d, e_d);
    check(t_cpu < t_dbg, "CPU ack did not come before the debug response");
    dbg_op(1'b0, 4'hf, 32'h34, 32'h0);
    cpu_op(1'b0, 4'hf, 32'h30, 32'h0);
    end_test("no preemption");

    // CPU parks on the bus with cyc alone, three debug reads pile up
    @(posedge wb_in_clk);
    #DRV_DLY;
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b0;
    cpu_req.we  = 1'b0;
    cpu_req.adr = '0;
    dbg_send(1'b0, 4'hf, 32'h10, 32'h0);
    dbg_send(1'b0, 4'hf, 32'h20, 32'h0);
    dbg_send(1'b0, 4'hf, 32'h34, 32'h0);
    check(dbg_busy, "host side not busy with a command parked behind a full output");
    cpu_req.cyc = 1'b0;
    dbg_wait(rd_d, e_d);
    check_result("debug", 1'b0, 4'hf, 32'h10, 32'h0, rd_d, e_d);
    dbg_wait(rd_d, e_d);
    check_result("debug", 1'b0, 4'hf, 32'h20, 32'h0, rd_d, e_d);
    dbg_wait(rd_d, e_d);
    check_result("debug", 1'b0, 4'hf, 32'h34, 32'h0, rd_d, e_d);
    check(!dbg_busy, "host side still busy after the queue drained");
    end_test("host back-pressure");

    // Out-of-range addresses alias word 0 in the low bits
    dbg_op(1'b1, 4'hf, 32'h0, 32'h0bad_f00d);
    dbg_op(1'b1, 4'hf, 32'h400, 32'h1111_1111);
    cpu_op(1'b1, 4'hf, 32'h800, 32'h2222_2222);
    dbg_op(1'b0, 4'hf, 32'h400, 32'h0);
    dbg_op(1'b0, 4'hf, 32'h0, 32'h0);
    cpu_op(1'b0, 4'hf, 32'h0, 32'h0);
    end_test("out of range");

    // A small window of words, one in five out of range
    for (int i = 0; i < RAND_OPS; i++) begin
      r_we  = $urandom_range(0, 1);
      r_sel = $urandom_range(0, 15);
      r_dat = $urandom;
      r_idx = $urandom_range(0, 39);
      if (r_idx >= 32) begin
        r_idx = r_idx + `MAM_MEM_WORDS - 32;
      end
      r_adr = r_idx << 2;
      if ($urandom_range(0, 1)) begin
        dbg_op(r_we, r_sel, r_adr, r_dat);
      end else begin
        cpu_op(r_we, r_sel, r_adr, r_dat);
      end
    end
    end_test("random mixed");

    $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, u_dut.u_adapter.u_assert.fail_cnt);
    if (total_errors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== mam_soc_top.sv ====
// Debug memory access top
`timescale 1ns/1ps
`include "mam_settings.svh"

module mam_soc_top
  import mam_pkg::*;
(
  input  logic               wb_in_clk_i,
  input  logic               wb_in_rst_i,
  // Debug host
  input  logic               dbg_valid_i,
  input  dbg_word_u          dbg_word_i,
  output logic               dbg_busy_o,
  output logic               rsp_valid_o,
  output logic [`MAM_DW-1:0] rdata_o,
  output logic               err_o,
  // CPU Wishbone port
  input  wb_req_t            cpu_req_i,
  output wb_rsp_t            cpu_rsp_o
);

  // Decoder to master
  mam_req_t dec_req;
  logic     dec_req_valid;
  logic     dec_req_take;

  // Master to adapter
  wb_req_t  mam_wb_req;
  wb_rsp_t  mam_wb_rsp;

  // Adapter to memory
  wb_req_t  mem_wb_req;
  wb_rsp_t  mem_wb_rsp;

  mam_cmd_decoder u_decoder (
    .wb_in_clk_i (wb_in_clk_i),
    .wb_in_rst_i (wb_in_rst_i),
    .dbg_valid_i (dbg_valid_i),
    .dbg_word_i  (dbg_word_i),
    .req_take_i  (dec_req_take),
    .dbg_busy_o  (dbg_busy_o),
    .req_valid_o (dec_req_valid),
    .req_o       (dec_req)
  );

  mam_wb_master u_master (
    .wb_in_clk_i (wb_in_clk_i),
    .wb_in_rst_i (wb_in_rst_i),
    .req_valid_i (dec_req_valid),
    .req_i       (dec_req),
    .wb_rsp_i    (mam_wb_rsp),
    .req_take_o  (dec_req_take),
    .wb_req_o    (mam_wb_req),
    .rsp_valid_o (rsp_valid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o)
  );

  mam_adapter_wb u_adapter (
    .wb_in_clk_i (wb_in_clk_i),
    .wb_in_rst_i (wb_in_rst_i),
    .cpu_req_i   (cpu_req_i),
    .cpu_rsp_o   (cpu_rsp_o),
    .mam_req_i   (mam_wb_req),
    .mam_rsp_o   (mam_wb_rsp),
    .mem_req_o   (mem_wb_req),
    .mem_rsp_i   (mem_wb_rsp)
  );

  wb_ram_slave u_ram (
    .wb_in_clk_i (wb_in_clk_i),
    .wb_in_rst_i (wb_in_rst_i),
    .wb_req_i    (mem_wb_req),
    .wb_rsp_o    (mem_wb_rsp)
  );

endmodule

// ==== mam_wb_master.sv ====
// Debug Wishbone master
`timescale 1ns/1ps
`include "mam_settings.svh"

module mam_wb_master
  import mam_pkg::*;
(
  input  logic               wb_in_clk_i,
  input  logic               wb_in_rst_i,
  input  logic               req_valid_i,
  input  mam_req_t           req_i,
  input  wb_rsp_t            wb_rsp_i,
  output logic               req_take_o,
  output wb_req_t            wb_req_o,
  output logic               rsp_valid_o,
  output logic [`MAM_DW-1:0] rdata_o,
  output logic               err_o
);

  typedef enum logic {
    ST_IDLE,
    ST_CYCLE
  } mst_state_e;

  mst_state_e         state_q;
  mam_req_t           hold_q;
  logic               bus_done;
  logic               rsp_valid_q;
  logic               err_q;
  logic [`MAM_DW-1:0] rdata_q;

  // Take a request only when the bus is free
  assign req_take_o = (state_q == ST_IDLE) & req_valid_i;

  // Slave ends the cycle
  assign bus_done = wb_rsp_i.ack | wb_rsp_i.err;

  ////////////////////////////////////////
  // Cycle engine
  ////////////////////////////////////////

  always_ff @(posedge wb_in_clk_i) begin
    if (wb_in_rst_i) begin
      state_q     <= ST_IDLE;
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      // Response strobe lasts one cycle
      rsp_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_take_o) begin
            state_q <= ST_CYCLE;
          end
        end
        ST_CYCLE: begin
          if (bus_done) begin
            state_q     <= ST_IDLE;
            rsp_valid_q <= 1'b1;
            err_q       <= wb_rsp_i.err;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request fields held for the whole cycle
  always_ff @(posedge wb_in_clk_i) begin
    if (req_take_o) begin
      hold_q <= req_i;
    end
    if (state_q == ST_CYCLE && bus_done) begin
      rdata_q <= wb_rsp_i.dat;
    end
  end

  // cyc and stb together, one single cycle per request
  always_comb begin
    wb_req_o.cyc = (state_q == ST_CYCLE);
    wb_req_o.stb = (state_q == ST_CYCLE);
    wb_req_o.we  = hold_q.we;
    wb_req_o.sel = hold_q.sel;
    wb_req_o.adr = hold_q.adr;
    wb_req_o.dat = hold_q.dat;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;

endmodule

// ==== sources.f ====
+incdir+.
mam_pkg.sv
mam_cmd_decoder.sv
mam_wb_master.sv
mam_adapter_wb.sv
wb_ram_slave.sv
mam_soc_top.sv
mam_soc_assert.sv
mam_soc_tb.sv

// ==== wb_ram_slave.sv ====
// Wishbone word RAM
`timescale 1ns/1ps
`include "mam_settings.svh"

module wb_ram_slave
  import mam_pkg::*;
(
  input  logic    wb_in_clk_i,
  input  logic    wb_in_rst_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  localparam int IW = $clog2(`MAM_MEM_WORDS);
  localparam int SW = `MAM_DW / 8;

  logic [`MAM_DW-1:0] mem [`MAM_MEM_WORDS];
  logic [`MAM_AW-3:0] word_idx;
  logic               in_range;
  logic               access;
  logic               ack_q;
  logic               err_q;
  logic [`MAM_DW-1:0] rdat_q;

  // Byte address to word index
  assign word_idx = wb_req_i.adr[`MAM_AW-1:2];
  assign in_range = (word_idx < `MAM_MEM_WORDS);

  // New access only when no response is out this cycle
  assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q & ~err_q;

  ////////////////////////////////////////
  // Response handshake
  ////////////////////////////////////////

  always_ff @(posedge wb_in_clk_i) begin
    if (wb_in_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access & in_range;
      err_q <= access & ~in_range;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge wb_in_clk_i) begin
    if (access && in_range) begin
      if (wb_req_i.we) begin
        // Byte lanes by sel
        for (int b = 0; b < SW; b++) begin
          if (wb_req_i.sel[b]) begin
            mem[word_idx[IW-1:0]][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
      end else begin
        rdat_q <= mem[word_idx[IW-1:0]];
      end
    end
  end

  // Read data sits next to ack
  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.err = err_q;
    wb_rsp_o.dat = rdat_q;
  end

endmodule
